// ==== hdl/decode_pkg.sv ====
`default_nettype none

package decode_pkg;

    typedef logic [31:0] inst_t;
    typedef logic [4:0]  reg_idx_t;
    // U-type value is kept unshifted
    typedef logic [19:0] imm20_t;

    typedef enum logic [4:0] {
        ALU_NONE, ALU_LUI, ALU_ADD, ALU_SUB, ALU_ADDW, ALU_SUBW,
        ALU_SLL, ALU_SRL, ALU_SRA, ALU_SLLW, ALU_SRLW, ALU_SRAW,
        ALU_XOR, ALU_OR, ALU_AND, ALU_SLT, ALU_SLTU
    } alu_op_e;

    typedef enum logic [4:0] {
        BRU_NONE, BRU_AUIPC, BRU_JAL, BRU_JALR,
        BRU_BEQ, BRU_BNE, BRU_BLT, BRU_BGE, BRU_BLTU, BRU_BGEU
    } bru_op_e;

    // divuw sits last so the other codes keep their place
    typedef enum logic [4:0] {
        MDU_NONE, MDU_MUL, MDU_MULW, MDU_MULH, MDU_MULHU, MDU_MULHSU,
        MDU_DIV, MDU_DIVW, MDU_DIVU, MDU_REM, MDU_REMW, MDU_REMU,
        MDU_REMUW, MDU_DIVUW
    } mdu_op_e;

    // one micro-op field read according to the issue queue
    typedef union packed {
        alu_op_e alu;
        bru_op_e bru;
        mdu_op_e mdu;
    } micop_u;

    typedef enum logic [1:0] {
        IQ_ALU = 2'd0,
        IQ_MDU = 2'd1,
        IQ_BRU = 2'd2
    } iq_id_e;

    typedef enum logic [1:0] {
        DISP_INT     = 2'd0,
        DISP_MEM     = 2'd1,
        DISP_UNKNOWN = 2'd2
    } disp_id_e;

    localparam logic [6:0] OPC_LUI      = 7'b0110111;
    localparam logic [6:0] OPC_AUIPC    = 7'b0010111;
    localparam logic [6:0] OPC_JAL      = 7'b1101111;
    localparam logic [6:0] OPC_JALR     = 7'b1100111;
    localparam logic [6:0] OPC_BRANCH   = 7'b1100011;
    localparam logic [6:0] OPC_LOAD     = 7'b0000011;
    localparam logic [6:0] OPC_STORE    = 7'b0100011;
    localparam logic [6:0] OPC_OP_IMM   = 7'b0010011;
    localparam logic [6:0] OPC_OP_IMM32 = 7'b0011011;
    localparam logic [6:0] OPC_OP       = 7'b0110011;
    localparam logic [6:0] OPC_OP32     = 7'b0111011;

    localparam logic [6:0] FUNCT7_MULDIV = 7'b0000001;

endpackage

`default_nettype wire

// ==== hdl/inst_class_if.sv ====
`timescale 1ns/100ps
`default_nettype none

interface inst_class_if;
    logic is_lui;
    logic is_auipc;
    logic is_jal;
    logic is_jalr;
    logic is_branch;
    logic is_load;
    logic is_store;
    logic is_op_imm;
    logic is_op_imm32;
    logic is_op;
    logic is_op32;
    // qualifies is_op / is_op32
    logic is_muldiv;
    logic is_shift_imm;
    logic unknown;

    modport src (
        output is_lui, is_auipc, is_jal, is_jalr, is_branch, is_load, is_store,
        output is_op_imm, is_op_imm32, is_op, is_op32, is_muldiv, is_shift_imm, unknown
    );

    modport dst (
        input is_lui, is_auipc, is_jal, is_jalr, is_branch, is_load, is_store,
        input is_op_imm, is_op_imm32, is_op, is_op32, is_muldiv, is_shift_imm, unknown
    );
endinterface

`default_nettype wire

// ==== hdl/inst_classify.sv ====
`timescale 1ns/100ps
`default_nettype none

module inst_classify #(
    parameter bit IS_RV64 = 1'b1
) (
    input wire decode_pkg::inst_t i_inst,
    inst_class_if.src class_if
);
    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    logic       f7_zero;
    logic       f7_alt;
    logic       f7_muldiv;
    logic       shamt_ok;
    logic       shamt_sra_ok;
    logic       legal;

    assign opcode    = i_inst[6:0];
    assign funct3    = i_inst[14:12];
    assign funct7    = i_inst[31:25];
    assign f7_zero   = (funct7 == 7'b0000000);
    assign f7_alt    = (funct7 == 7'b0100000);
    assign f7_muldiv = (funct7 == decode_pkg::FUNCT7_MULDIV);

    // rv64 shamt borrows funct7 bit 0
    assign shamt_ok     = IS_RV64 ? (funct7[6:1] == 6'b000000) : f7_zero;
    assign shamt_sra_ok = IS_RV64 ? (funct7[6:1] == 6'b010000) : f7_alt;

    // compressed words never match since their low bits are not 2'b11
    always_comb begin
        legal = 1'b0;
        case (opcode)
            decode_pkg::OPC_LUI,
            decode_pkg::OPC_AUIPC,
            decode_pkg::OPC_JAL:    legal = 1'b1;
            decode_pkg::OPC_JALR:   legal = (funct3 == 3'b000);
            decode_pkg::OPC_BRANCH: legal = (funct3[2:1] != 2'b01);
            // ld and lwu only exist on rv64
            decode_pkg::OPC_LOAD:   legal = (funct3 != 3'b111) &&
                                            (IS_RV64 || (funct3 != 3'b011 && funct3 != 3'b110));
            decode_pkg::OPC_STORE:  legal = !funct3[2] && (IS_RV64 || funct3 != 3'b011);
            decode_pkg::OPC_OP_IMM: begin
                case (funct3)
                    3'b001:  legal = shamt_ok;
                    3'b101:  legal = shamt_ok || shamt_sra_ok;
                    default: legal = 1'b1;
                endcase
            end
            decode_pkg::OPC_OP_IMM32: legal = IS_RV64 && ((funct3 == 3'b000) ||
                                              (funct3 == 3'b001 && f7_zero) ||
                                              (funct3 == 3'b101 && (f7_zero || f7_alt)));
            decode_pkg::OPC_OP:     legal = f7_zero || f7_muldiv ||
                                            (f7_alt && (funct3 == 3'b000 || funct3 == 3'b101));
            decode_pkg::OPC_OP32:   legal = IS_RV64 && (
                (f7_zero && (funct3 == 3'b000 || funct3 == 3'b001 || funct3 == 3'b101)) ||
                (f7_alt && (funct3 == 3'b000 || funct3 == 3'b101)) ||
                (f7_muldiv && (funct3 == 3'b000 || funct3[2])));
            default:                legal = 1'b0;
        endcase
    end

    assign class_if.unknown     = !legal;
    assign class_if.is_lui      = legal && (opcode == decode_pkg::OPC_LUI);
    assign class_if.is_auipc    = legal && (opcode == decode_pkg::OPC_AUIPC);
    assign class_if.is_jal      = legal && (opcode == decode_pkg::OPC_JAL);
    assign class_if.is_jalr     = legal && (opcode == decode_pkg::OPC_JALR);
    assign class_if.is_branch   = legal && (opcode == decode_pkg::OPC_BRANCH);
    assign class_if.is_load     = legal && (opcode == decode_pkg::OPC_LOAD);
    assign class_if.is_store    = legal && (opcode == decode_pkg::OPC_STORE);
    assign class_if.is_op_imm   = legal && (opcode == decode_pkg::OPC_OP_IMM);
    assign class_if.is_op_imm32 = legal && (opcode == decode_pkg::OPC_OP_IMM32);
    assign class_if.is_op       = legal && (opcode == decode_pkg::OPC_OP);
    assign class_if.is_op32     = legal && (opcode == decode_pkg::OPC_OP32);

    assign class_if.is_muldiv = legal && f7_muldiv &&
                                (opcode == decode_pkg::OPC_OP || opcode == decode_pkg::OPC_OP32);
    assign class_if.is_shift_imm = legal && (funct3[1:0] == 2'b01) &&
        (opcode == decode_pkg::OPC_OP_IMM || opcode == decode_pkg::OPC_OP_IMM32);

    // opcode classes exclude each other
    a_class_onehot: assert property (@(i_inst) $onehot0({
        class_if.is_lui, class_if.is_auipc, class_if.is_jal, class_if.is_jalr,
        class_if.is_branch, class_if.is_load, class_if.is_store, class_if.is_op_imm,
        class_if.is_op_imm32, class_if.is_op, class_if.is_op32}));

endmodule

`default_nettype wire

// ==== hdl/imm_gen.sv ====
`timescale 1ns/100ps
`default_nettype none

module imm_gen #(
    parameter bit IS_RV64 = 1'b1
) (
    input wire decode_pkg::inst_t i_inst,
    inst_class_if.dst class_if,
    output decode_pkg::imm20_t o_imm20
);
    decode_pkg::imm20_t imm_i;
    decode_pkg::imm20_t imm_s;
    decode_pkg::imm20_t imm_b;
    decode_pkg::imm20_t imm_u;
    decode_pkg::imm20_t imm_j;
    decode_pkg::imm20_t imm_shamt;

    assign imm_i = {{8{i_inst[31]}}, i_inst[31:20]};
    assign imm_s = {{8{i_inst[31]}}, i_inst[31:25], i_inst[11:7]};
    assign imm_b = {{8{i_inst[31]}}, i_inst[7], i_inst[30:25], i_inst[11:8], 1'b0};
    assign imm_u = i_inst[31:12];
    // top bit of the j offset does not fit
    assign imm_j = {i_inst[19:12], i_inst[20], i_inst[30:21], 1'b0};
    assign imm_shamt = IS_RV64 ? {14'h0, i_inst[25:20]} : {15'h0, i_inst[24:20]};

    always_comb begin
        if (class_if.is_lui || class_if.is_auipc) begin
            o_imm20 = imm_u;
        end else if (class_if.is_branch) begin
            o_imm20 = imm_b;
        end else if (class_if.is_store) begin
            o_imm20 = imm_s;
        end else if (class_if.is_shift_imm) begin
            o_imm20 = imm_shamt;
        end else if (class_if.is_load || class_if.is_jalr ||
                     class_if.is_op_imm || class_if.is_op_imm32) begin
            o_imm20 = imm_i;
        end else if (class_if.is_jal) begin
            o_imm20 = imm_j;
        end else begin
            o_imm20 = '0;
        end
    end

endmodule

`default_nettype wire

// ==== hdl/micop_select.sv ====
`timescale 1ns/100ps
`default_nettype none

module micop_select (
    input wire decode_pkg::inst_t i_inst,
    inst_class_if.dst class_if,
    output decode_pkg::micop_u o_micop,
    output decode_pkg::iq_id_e o_issue_q,
    output decode_pkg::disp_id_e o_disp_q
);
    logic [2:0] funct3;
    logic       f7_b5;
    logic       wide;
    logic       int_math;
    decode_pkg::alu_op_e alu_op;
    decode_pkg::bru_op_e bru_op;
    decode_pkg::mdu_op_e mdu_op;

    assign funct3 = i_inst[14:12];
    assign f7_b5  = i_inst[30];
    assign wide   = class_if.is_op_imm32 || class_if.is_op32;
    assign int_math = !class_if.is_muldiv && (class_if.is_op_imm || class_if.is_op_imm32 ||
                                              class_if.is_op || class_if.is_op32);

    always_comb begin
        alu_op = decode_pkg::ALU_NONE;
        if (class_if.is_lui) begin
            alu_op = decode_pkg::ALU_LUI;
        end else if (int_math) begin
            case (funct3)
                // only register forms subtract since addi may carry bit 30
                3'b000: begin
                    if ((class_if.is_op || class_if.is_op32) && f7_b5) begin
                        alu_op = wide ? decode_pkg::ALU_SUBW : decode_pkg::ALU_SUB;
                    end else begin
                        alu_op = wide ? decode_pkg::ALU_ADDW : decode_pkg::ALU_ADD;
                    end
                end
                3'b001: alu_op = wide ? decode_pkg::ALU_SLLW : decode_pkg::ALU_SLL;
                3'b101: begin
                    if (f7_b5) begin
                        alu_op = wide ? decode_pkg::ALU_SRAW : decode_pkg::ALU_SRA;
                    end else begin
                        alu_op = wide ? decode_pkg::ALU_SRLW : decode_pkg::ALU_SRL;
                    end
                end
                3'b010: alu_op = decode_pkg::ALU_SLT;
                3'b011: alu_op = decode_pkg::ALU_SLTU;
                3'b100: alu_op = decode_pkg::ALU_XOR;
                3'b110: alu_op = decode_pkg::ALU_OR;
                default: alu_op = decode_pkg::ALU_AND;
            endcase
        end
    end

    always_comb begin
        bru_op = decode_pkg::BRU_NONE;
        if (class_if.is_auipc) begin
            bru_op = decode_pkg::BRU_AUIPC;
        end else if (class_if.is_jal) begin
            bru_op = decode_pkg::BRU_JAL;
        end else if (class_if.is_jalr) begin
            bru_op = decode_pkg::BRU_JALR;
        end else if (class_if.is_branch) begin
            case (funct3)
                3'b000:  bru_op = decode_pkg::BRU_BEQ;
                3'b001:  bru_op = decode_pkg::BRU_BNE;
                3'b100:  bru_op = decode_pkg::BRU_BLT;
                3'b101:  bru_op = decode_pkg::BRU_BGE;
                3'b110:  bru_op = decode_pkg::BRU_BLTU;
                default: bru_op = decode_pkg::BRU_BGEU;
            endcase
        end
    end

    always_comb begin
        mdu_op = decode_pkg::MDU_NONE;
        if (class_if.is_muldiv) begin
            case (funct3)
                3'b000:  mdu_op = wide ? decode_pkg::MDU_MULW : decode_pkg::MDU_MUL;
                3'b001:  mdu_op = decode_pkg::MDU_MULH;
                3'b010:  mdu_op = decode_pkg::MDU_MULHSU;
                3'b011:  mdu_op = decode_pkg::MDU_MULHU;
                3'b100:  mdu_op = wide ? decode_pkg::MDU_DIVW : decode_pkg::MDU_DIV;
                3'b101:  mdu_op = wide ? decode_pkg::MDU_DIVUW : decode_pkg::MDU_DIVU;
                3'b110:  mdu_op = wide ? decode_pkg::MDU_REMW : decode_pkg::MDU_REM;
                default: mdu_op = wide ? decode_pkg::MDU_REMUW : decode_pkg::MDU_REMU;
            endcase
        end
    end

    always_comb begin
        o_micop = '0;
        if (class_if.is_muldiv) begin
            o_micop.mdu = mdu_op;
        end else if (alu_op != decode_pkg::ALU_NONE) begin
            o_micop.alu = alu_op;
        end else begin
            o_micop.bru = bru_op;
        end
    end

    always_comb begin
        if (class_if.is_muldiv) begin
            o_issue_q = decode_pkg::IQ_MDU;
        end else if (int_math || class_if.is_lui) begin
            o_issue_q = decode_pkg::IQ_ALU;
        end else begin
            o_issue_q = decode_pkg::IQ_BRU;
        end
    end

    always_comb begin
        if (class_if.unknown) begin
            o_disp_q = decode_pkg::DISP_UNKNOWN;
        end else if (class_if.is_load || class_if.is_store) begin
            o_disp_q = decode_pkg::DISP_MEM;
        end else begin
            o_disp_q = decode_pkg::DISP_INT;
        end
    end

    // every integer-block instruction and nothing else carries a micro-op
    a_micop_int: assert property (@(i_inst)
        (o_micop != '0) == (o_disp_q == decode_pkg::DISP_INT));

endmodule

`default_nettype wire

// ==== hdl/decode_stage.sv ====
`timescale 1ns/100ps
`default_nettype none

module decode_stage #(
    parameter bit IS_RV64 = 1'b1
) (
    input wire i_clk,
    input wire i_rst,
    input wire i_inst_valid,
    input wire decode_pkg::inst_t i_inst,
    output logic o_dec_valid,
    output logic o_unknown_inst,
    output logic o_rd_wen,
    output decode_pkg::reg_idx_t o_rd_idx,
    output decode_pkg::reg_idx_t o_rs1_idx,
    output decode_pkg::reg_idx_t o_rs2_idx,
    output logic o_use_imm,
    output decode_pkg::imm20_t o_imm20,
    output decode_pkg::micop_u o_micop,
    output decode_pkg::iq_id_e o_issue_q,
    output decode_pkg::disp_id_e o_disp_q,
    output logic o_is_store,
    output logic o_is_mv
);
    inst_class_if class_if ();

    decode_pkg::imm20_t   imm20;
    decode_pkg::micop_u   micop;
    decode_pkg::iq_id_e   issue_q;
    decode_pkg::disp_id_e disp_q;
    decode_pkg::reg_idx_t rd_field;
    decode_pkg::reg_idx_t rs1_field;
    decode_pkg::reg_idx_t rs2_field;
    logic has_rd;
    logic has_rs1;
    logic has_rs2;
    logic rd_wen;
    logic use_imm;
    logic is_add;
    logic is_mv;

    inst_classify #(.IS_RV64(IS_RV64)) inst_classify_i (
        .i_inst   (i_inst),
        .class_if (class_if.src)
    );

    imm_gen #(.IS_RV64(IS_RV64)) imm_gen_i (
        .i_inst   (i_inst),
        .class_if (class_if.dst),
        .o_imm20  (imm20)
    );

    micop_select micop_select_i (
        .i_inst    (i_inst),
        .class_if  (class_if.dst),
        .o_micop   (micop),
        .o_issue_q (issue_q),
        .o_disp_q  (disp_q)
    );

    assign rd_field  = i_inst[11:7];
    assign rs1_field = i_inst[19:15];
    assign rs2_field = i_inst[24:20];

    // muldiv rides on is_op / is_op32, so it writes rd too
    assign has_rd = class_if.is_lui || class_if.is_auipc || class_if.is_jal ||
                    class_if.is_jalr || class_if.is_load || class_if.is_op_imm ||
                    class_if.is_op_imm32 || class_if.is_op || class_if.is_op32;
    assign has_rs1 = class_if.is_jalr || class_if.is_branch || class_if.is_load ||
                     class_if.is_store || class_if.is_op_imm || class_if.is_op_imm32 ||
                     class_if.is_op || class_if.is_op32;
    assign has_rs2 = class_if.is_branch || class_if.is_store || class_if.is_op ||
                     class_if.is_op32;
    assign rd_wen  = has_rd && (rd_field != '0);
    assign use_imm = class_if.is_lui || class_if.is_auipc || class_if.is_jal ||
                     class_if.is_jalr || class_if.is_branch || class_if.is_load ||
                     class_if.is_store || class_if.is_op_imm || class_if.is_op_imm32;

    // addi rd, rs, 0 and add rd, rs, x0
    assign is_add = class_if.is_op && !class_if.is_muldiv && !i_inst[30] &&
                    (i_inst[14:12] == 3'b000);
    assign is_mv  = (class_if.is_op_imm && (i_inst[14:12] == 3'b000) && (imm20 == '0)) ||
                    (is_add && (rs2_field == '0));

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            o_dec_valid    <= 1'b0;
            o_unknown_inst <= 1'b0;
            o_rd_wen       <= 1'b0;
            o_rd_idx       <= '0;
            o_rs1_idx      <= '0;
            o_rs2_idx      <= '0;
            o_use_imm      <= 1'b0;
            o_imm20        <= '0;
            o_micop        <= '0;
            o_issue_q      <= decode_pkg::IQ_ALU;
            o_disp_q       <= decode_pkg::DISP_INT;
            o_is_store     <= 1'b0;
            o_is_mv        <= 1'b0;
        end else begin
            o_dec_valid <= i_inst_valid;
            if (i_inst_valid) begin
                o_unknown_inst <= class_if.unknown;
                o_rd_wen       <= rd_wen;
                o_rd_idx       <= rd_wen ? rd_field : '0;
                o_rs1_idx      <= has_rs1 ? rs1_field : '0;
                o_rs2_idx      <= has_rs2 ? rs2_field : '0;
                o_use_imm      <= use_imm;
                o_imm20        <= imm20;
                o_micop        <= micop;
                o_issue_q      <= issue_q;
                o_disp_q       <= disp_q;
                o_is_store     <= class_if.is_store;
                o_is_mv        <= is_mv;
            end
        end
    end

    a_rd_wen_nonzero: assert property (@(posedge i_clk) disable iff (i_rst)
        o_rd_wen |-> (o_rd_idx != '0));

endmodule

`default_nettype wire

// ==== tb/tb_clock.sv ====
`timescale 1ns/100ps
`default_nettype none

module tb_clock #(
    parameter int PERIOD = 40
) (
    output logic o_clk
);
    initial begin
        o_clk = 1'b0;
        forever #(PERIOD / 2) o_clk = ~o_clk;
    end
endmodule

`default_nettype wire

// ==== tb/decode_stage_tb.sv ====
`timescale 1ns/100ps
`default_nettype none

module decode_stage_tb;
    localparam int    RESET_CYCLES  = 10;
    localparam int    RESET_TIMEOUT = 50;
    localparam int    MAX_LINES     = 256;
    localparam string VECTOR_FILE   = "tb/decode_vectors.txt";

    // one row of the vector file
    typedef struct {
        decode_pkg::inst_t    inst;
        logic                 valid;
        logic                 unknown;
        logic                 rd_wen;
        decode_pkg::reg_idx_t rd;
        decode_pkg::reg_idx_t rs1;
        decode_pkg::reg_idx_t rs2;
        logic                 use_imm;
        decode_pkg::imm20_t   imm20;
        decode_pkg::micop_u   micop;
        decode_pkg::iq_id_e   iq;
        decode_pkg::disp_id_e disp;
        logic                 is_store;
        logic                 is_mv;
    } vector_t;

    logic clk;
    logic rst;
    logic inst_valid;
    decode_pkg::inst_t inst;
    logic dec_valid;
    logic unknown_inst;
    logic rd_wen;
    decode_pkg::reg_idx_t rd_idx;
    decode_pkg::reg_idx_t rs1_idx;
    decode_pkg::reg_idx_t rs2_idx;
    logic use_imm;
    decode_pkg::imm20_t imm20;
    decode_pkg::micop_u micop;
    decode_pkg::iq_id_e issue_q;
    decode_pkg::disp_id_e disp_q;
    logic is_store;
    logic is_mv;

    vector_t vectors[$];
    string cur_step;

    tb_clock #(.PERIOD(40)) clock_i (.o_clk(clk));

    decode_stage #(.IS_RV64(1'b1)) decode_stage_i (
        .i_clk          (clk),
        .i_rst          (rst),
        .i_inst_valid   (inst_valid),
        .i_inst         (inst),
        .o_dec_valid    (dec_valid),
        .o_unknown_inst (unknown_inst),
        .o_rd_wen       (rd_wen),
        .o_rd_idx       (rd_idx),
        .o_rs1_idx      (rs1_idx),
        .o_rs2_idx      (rs2_idx),
        .o_use_imm      (use_imm),
        .o_imm20        (imm20),
        .o_micop        (micop),
        .o_issue_q      (issue_q),
        .o_disp_q       (disp_q),
        .o_is_store     (is_store),
        .o_is_mv        (is_mv)
    );

    task automatic report_failure(input string msg);
        $display("%s", msg);
        $display("*** TEST FAILED ***");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic flag_check(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            report_failure($sformatf("error at %0t: %s, %s is %0b, expected %0b",
                                     $time, cur_step, name, got, exp));
        end
    endtask

    task automatic reg_idx_check(input string name, input decode_pkg::reg_idx_t got,
                                 input decode_pkg::reg_idx_t exp);
        if (got !== exp) begin
            report_failure($sformatf("error at %0t: %s, %s is x%0d, expected x%0d",
                                     $time, cur_step, name, got, exp));
        end
    endtask

    task automatic imm_check(input decode_pkg::imm20_t got, input decode_pkg::imm20_t exp);
        if (got !== exp) begin
            report_failure($sformatf("error at %0t: %s, imm20 is %05h, expected %05h",
                                     $time, cur_step, got, exp));
        end
    endtask

    task automatic micop_check(input decode_pkg::micop_u got, input decode_pkg::micop_u exp);
        if (got !== exp) begin
            report_failure($sformatf("error at %0t: %s, micop is %0d, expected %0d",
                                     $time, cur_step, got, exp));
        end
    endtask

    task automatic issue_q_check(input decode_pkg::iq_id_e got, input decode_pkg::iq_id_e exp);
        if (got !== exp) begin
            report_failure($sformatf("error at %0t: %s, issue queue is %0d, expected %0d",
                                     $time, cur_step, got, exp));
        end
    endtask

    task automatic disp_q_check(input decode_pkg::disp_id_e got,
                                input decode_pkg::disp_id_e exp);
        if (got !== exp) begin
            report_failure($sformatf("error at %0t: %s, dispatch block is %0d, expected %0d",
                                     $time, cur_step, got, exp));
        end
    endtask

    function automatic vector_t zero_vector();
        vector_t v;
        v.inst     = '0;
        v.valid    = 1'b0;
        v.unknown  = 1'b0;
        v.rd_wen   = 1'b0;
        v.rd       = '0;
        v.rs1      = '0;
        v.rs2      = '0;
        v.use_imm  = 1'b0;
        v.imm20    = '0;
        v.micop    = '0;
        v.iq       = decode_pkg::IQ_ALU;
        v.disp     = decode_pkg::DISP_INT;
        v.is_store = 1'b0;
        v.is_mv    = 1'b0;
        return v;
    endfunction

    task automatic load_vectors();
        int fd;
        int n;
        int count;
        string line;
        vector_t v;
        logic [31:0] col[14];
        fd = $fopen(VECTOR_FILE, "r");
        if (fd == 0) begin
            report_failure({"could not open the vector file ", VECTOR_FILE});
        end
        count = 0;
        while (!$feof(fd) && count < MAX_LINES) begin
            count++;
            n = $fgets(line, fd);
            // skip blank lines and the column comments
            if (n > 1 && line.getc(0) != "#") begin
                n = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                            col[0], col[1], col[2], col[3], col[4], col[5], col[6],
                            col[7], col[8], col[9], col[10], col[11], col[12], col[13]);
                if (n != 14) begin
                    report_failure($sformatf("line %0d of the vector file has %0d fields, not 14",
                                             count, n));
                end
                v.inst     = col[0];
                v.valid    = col[1][0];
                v.unknown  = col[2][0];
                v.rd_wen   = col[3][0];
                v.rd       = col[4][4:0];
                v.rs1      = col[5][4:0];
                v.rs2      = col[6][4:0];
                v.use_imm  = col[7][0];
                v.imm20    = col[8][19:0];
                v.micop    = col[9][4:0];
                v.iq       = decode_pkg::iq_id_e'(col[10][1:0]);
                v.disp     = decode_pkg::disp_id_e'(col[11][1:0]);
                v.is_store = col[12][0];
                v.is_mv    = col[13][0];
                vectors.push_back(v);
            end
        end
        $fclose(fd);
        if (vectors.size() == 0) begin
            report_failure("the vector file holds no vectors");
        end
    endtask

    task automatic wait_reset_release();
        int cycles;
        cycles = 0;
        while (rst) begin
            @(posedge clk);
            cycles++;
            if (cycles > RESET_TIMEOUT) begin
                report_failure("reset was never released");
            end
        end
        // back onto the falling edge for driving
        @(negedge clk);
    endtask

    task automatic drive_vector(input vector_t v);
        inst_valid = v.valid;
        inst       = v.inst;
    endtask

    task automatic check_result(input vector_t v);
        flag_check("dec_valid", dec_valid, v.valid);
        flag_check("unknown_inst", unknown_inst, v.unknown);
        flag_check("rd_wen", rd_wen, v.rd_wen);
        reg_idx_check("rd_idx", rd_idx, v.rd);
        reg_idx_check("rs1_idx", rs1_idx, v.rs1);
        reg_idx_check("rs2_idx", rs2_idx, v.rs2);
        flag_check("use_imm", use_imm, v.use_imm);
        imm_check(imm20, v.imm20);
        micop_check(micop, v.micop);
        issue_q_check(issue_q, v.iq);
        disp_q_check(disp_q, v.disp);
        flag_check("is_store", is_store, v.is_store);
        flag_check("is_mv", is_mv, v.is_mv);
    endtask

    // reset held for a fixed number of cycles, released on a falling edge
    initial begin
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
    end

    initial begin
        rst        = 1'b1;
        inst_valid = 1'b0;
        inst       = '0;
        cur_step   = "reset";
        load_vectors();
        wait_reset_release();
        check_result(zero_vector());

        // each row is checked on the falling edge after the one that drove it
        foreach (vectors[i]) begin
            drive_vector(vectors[i]);
            @(negedge clk);
            cur_step = $sformatf("vector %0d", i);
            check_result(vectors[i]);
        end
        inst_valid = 1'b0;

        $display("%0d vectors checked", vectors.size());
        $display("*** TEST PASSED ***");
        $finish;
    end
endmodule

`default_nettype wire

// ==== decode_stage.f ====
hdl/decode_pkg.sv
hdl/inst_class_if.sv
hdl/inst_classify.sv
hdl/imm_gen.sv
hdl/micop_select.sv
hdl/decode_stage.sv
tb/tb_clock.sv
tb/decode_stage_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the decode stage testbench with Verilator.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 \
    --top-module decode_stage_tb \
    -f decode_stage.f \
    -o decode_stage_sim
status=$?
if [ $status -ne 0 ]; then
    echo "verilator build failed with status $status"
    exit 1
fi

out=$(./obj_dir/decode_stage_sim 2>&1)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$out" | grep -qF '*** TEST PASSED ***'; then
    exit 0
else
    echo "pass message not found in simulation output"
    exit 1
fi

// ==== tb/decode_vectors.txt ====
# inst valid unknown rd_wen rd rs1 rs2 use_imm imm20 micop issue_q disp is_store is_mv
# all hex; a row with valid 0 expects the previous outputs held
00000013 0 0 0 00 00 00 0 00000 00 0 0 0 0
003100b3 1 0 1 01 02 03 0 00000 02 0 0 0 0
407302b3 1 0 1 05 06 07 0 00000 03 0 0 0 0
000100b3 1 0 1 01 02 00 0 00000 02 0 0 0 1
00010093 1 0 1 01 02 00 1 00000 02 0 0 0 1
ffb20193 1 0 1 03 04 00 1 ffffb 02 0 0 0 0
00108013 1 0 0 00 01 00 1 00001 02 0 0 0 0
02131293 1 0 1 05 06 00 1 00021 06 0 0 0 0
40345393 1 0 1 07 08 00 1 00003 08 0 0 0 0
00c5853b 1 0 1 0a 0b 0c 0 00000 04 0 0 0 0
4041509b 1 0 1 01 02 00 1 00004 0b 0 0 0 0
0062b233 1 0 1 04 05 06 0 00000 10 0 0 0 0
07f4f493 1 0 1 09 09 00 1 0007f 0e 0 0 0 0
00208863 1 0 0 00 01 02 1 00010 04 2 0 0 0
00000000 0 0 0 00 01 02 1 00010 04 2 0 0 0
fe419ce3 1 0 0 00 03 04 1 ffff8 05 2 0 0 0
0062e263 1 0 0 00 05 06 1 00004 08 2 0 0 0
ffdff0ef 1 0 1 01 00 00 1 ffffc 02 2 0 0 0
008280e7 1 0 1 01 05 00 1 00008 03 2 0 0 0
12345117 1 0 1 02 00 00 1 12345 01 2 0 0 0
abcde1b7 1 0 1 03 00 00 1 abcde 01 0 0 0 0
ff03b303 1 0 1 06 07 00 1 ffff0 00 2 1 0 0
0084aa23 1 0 0 00 09 08 1 00014 00 2 1 1 0
fe113c23 1 0 0 00 02 01 1 ffff8 00 2 1 1 0
023100b3 1 0 1 01 02 03 0 00000 01 1 0 0 0
0262e23b 1 0 1 04 05 06 0 00000 0a 1 0 0 0
0220b033 1 0 0 00 01 02 0 00000 04 1 0 0 0
00004501 1 1 0 00 00 00 0 00000 00 2 2 0 0
0021a0af 1 1 0 00 00 00 0 00000 00 2 2 0 0
003100d3 1 1 0 00 00 00 0 00000 00 2 2 0 0
300110f3 1 1 0 00 00 00 0 00000 00 2 2 0 0
